/* design/mem_bank_if.sv */
`default_nettype none

interface mem_bank_if
  import mem_pkg::*;
();

  logic  read;
  logic  write;
  row_t  addr;
  word_t bw;
  word_t din;
  word_t dout;

  modport ctrl (
    output read,
    output write,
    output addr,
    output bw,
    output din,
    input  dout
  );

  modport bank (
    input  read,
    input  write,
    input  addr,
    input  bw,
    input  din,
    output dout
  );

endinterface

`default_nettype wire

/* design/mem_pkg.sv */
`default_nettype none

package mem_pkg;

  localparam int WIDTH   = 32;
  localparam int NUMADDR = 1024;
  localparam int BITADDR = 10;

  // Banks and rows within a bank.
  localparam int NUMWBNK = 4;
  localparam int BITWBNK = 2;
  localparam int NUMWROW = 256;
  localparam int BITWROW = 8;

  typedef logic [WIDTH-1:0]           word_t;  // Data word, also used as bit mask.
  typedef logic [BITADDR-1:0]         addr_t;
  typedef logic [BITWBNK-1:0]         bank_t;
  typedef logic [BITWROW-1:0]         row_t;
  typedef logic [BITWBNK+BITWROW-1:0] padr_t;  // Bank index sits above the row.

endpackage

`default_nettype wire

/* design/np2_addr.sv */
`default_nettype none

module np2_addr
  import mem_pkg::*;
(
  input  addr_t vaddr,
  output bank_t vbadr,
  output row_t  vradr
);

  localparam bit BNK_POW2 = ((NUMWBNK & (NUMWBNK - 1)) == 0);

  generate
    if (BNK_POW2) begin : g_pow2
      // Modulo and divide reduce to a bit split of the address.
      assign vbadr = bank_t'(vaddr % NUMWBNK);
      assign vradr = row_t'(vaddr >> BITWBNK);
    end else begin : g_np2
      int unsigned full_addr;
      int unsigned bank_idx;
      int unsigned row_idx;

      always_comb begin
        full_addr = int'(vaddr);
        bank_idx  = full_addr % NUMWBNK;   // Consecutive words land in consecutive banks.
        row_idx   = full_addr / NUMWBNK;
        vbadr     = bank_t'(bank_idx);
        vradr     = row_t'(row_idx);
      end
    end
  endgenerate

endmodule

`default_nettype wire

/* design/pseudo_mem_top.sv */
`default_nettype none

module pseudo_mem_top
  import mem_pkg::*;
#(
  parameter int SRAM_DELAY = 2,
  parameter int FLOPCMD    = 1,
  parameter int FLOPMEM    = 0,
  parameter int FLOPOUT    = 1
) (
  input  wire   clk,
  input  wire   rst_n,

  input  wire   write,
  input  addr_t wr_adr,
  input  word_t bw,
  input  word_t din,

  input  wire   read,
  input  addr_t rd_adr,

  output logic  rd_vld,
  output word_t rd_dout,
  output padr_t rd_padr
);

  mem_bank_if bank_if [NUMWBNK] ();

  stack_pseudo #(
    .SRAM_DELAY (SRAM_DELAY),
    .FLOPCMD    (FLOPCMD),
    .FLOPMEM    (FLOPMEM),
    .FLOPOUT    (FLOPOUT)
  ) i_stack_pseudo (
    .clk     (clk),
    .rst_n   (rst_n),
    .write   (write),
    .wr_adr  (wr_adr),
    .bw      (bw),
    .din     (din),
    .read    (read),
    .rd_adr  (rd_adr),
    .rd_vld  (rd_vld),
    .rd_dout (rd_dout),
    .rd_padr (rd_padr),
    .bank    (bank_if)
  );

  for (genvar i = 0; i < NUMWBNK; i++) begin : g_sram
    sram_bank #(
      .SRAM_DELAY (SRAM_DELAY)
    ) i_sram_bank (
      .clk  (clk),
      .bank (bank_if[i])
    );
  end

endmodule

`default_nettype wire

/* design/sram_bank.sv */
`default_nettype none

module sram_bank
  import mem_pkg::*;
#(
  parameter int SRAM_DELAY = 2
) (
  input  wire       clk,
  mem_bank_if.bank  bank
);

  word_t mem [NUMWROW];
  word_t rd_pipe [SRAM_DELAY];

  always_ff @(posedge clk) begin
    if (bank.write) begin
      // Only bits with a set mask bit take the new value.
      mem[bank.addr] <= (mem[bank.addr] & ~bank.bw) | (bank.din & bank.bw);
    end
  end

  always_ff @(posedge clk) begin
    if (bank.read) begin
      rd_pipe[0] <= mem[bank.addr];  // First stage holds until the next read.
    end
    for (int i = 1; i < SRAM_DELAY; i++) begin
      rd_pipe[i] <= rd_pipe[i-1];
    end
  end

  assign bank.dout = rd_pipe[SRAM_DELAY-1];

endmodule

`default_nettype wire

/* design/stack_pseudo.sv */
`default_nettype none

module stack_pseudo
  import mem_pkg::*;
#(
  parameter int SRAM_DELAY = 2,
  parameter int FLOPCMD    = 1,
  parameter int FLOPMEM    = 0,
  parameter int FLOPOUT    = 1
) (
  input  wire        clk,
  input  wire        rst_n,
  input  wire        write,
  input  addr_t      wr_adr,
  input  word_t      bw,
  input  word_t      din,
  input  wire        read,
  input  addr_t      rd_adr,
  output logic       rd_vld,
  output word_t      rd_dout,
  output padr_t      rd_padr,
  mem_bank_if.ctrl   bank [NUMWBNK]
);

  localparam int TAG_DEPTH = SRAM_DELAY + FLOPCMD + FLOPMEM;

  bank_t wr_bank;
  row_t  wr_row;
  bank_t rd_bank;
  row_t  rd_row;

  logic [NUMWBNK-1:0] cmd_read;
  logic [NUMWBNK-1:0] cmd_write;
  row_t               cmd_addr [NUMWBNK];

  logic [NUMWBNK-1:0] mem_read;
  logic [NUMWBNK-1:0] mem_write;
  row_t               mem_addr [NUMWBNK];
  word_t              mem_bw;
  word_t              mem_din;
  word_t              mem_dout [NUMWBNK];
  word_t              dout_q [NUMWBNK];

  logic [TAG_DEPTH-1:0] tag_vld;
  bank_t                tag_bank [TAG_DEPTH];
  row_t                 tag_row [TAG_DEPTH];

  logic  res_vld;
  word_t res_dout;
  padr_t res_padr;

  np2_addr i_wr_addr (
    .vaddr (wr_adr),
    .vbadr (wr_bank),
    .vradr (wr_row)
  );

  np2_addr i_rd_addr (
    .vaddr (rd_adr),
    .vbadr (rd_bank),
    .vradr (rd_row)
  );

  always_comb begin
    for (int i = 0; i < NUMWBNK; i++) begin
      cmd_read[i]  = read && (rd_bank == bank_t'(i));
      cmd_write[i] = write && (wr_bank == bank_t'(i));
      cmd_addr[i]  = cmd_read[i] ? rd_row : wr_row;
    end
  end

  generate
    if (FLOPCMD != 0) begin : g_flop_cmd
      always_ff @(posedge clk) begin
        if (!rst_n) begin
          mem_read  <= '0;
          mem_write <= '0;
        end else begin
          mem_read  <= cmd_read;
          mem_write <= cmd_write;
        end
      end

      always_ff @(posedge clk) begin
        mem_addr <= cmd_addr;
        mem_bw   <= bw;
        mem_din  <= din;
      end
    end else begin : g_no_flop_cmd
      assign mem_read  = cmd_read;
      assign mem_write = cmd_write;
      assign mem_addr  = cmd_addr;
      assign mem_bw    = bw;
      assign mem_din   = din;
    end
  endgenerate

  for (genvar i = 0; i < NUMWBNK; i++) begin : g_bank
    assign bank[i].read  = mem_read[i];
    assign bank[i].write = mem_write[i];
    assign bank[i].addr  = mem_addr[i];
    assign bank[i].bw    = mem_bw;   // Every bank sees the same mask and data.
    assign bank[i].din   = mem_din;
    assign mem_dout[i]   = bank[i].dout;
  end

  generate
    if (FLOPMEM != 0) begin : g_flop_mem
      always_ff @(posedge clk) begin
        dout_q <= mem_dout;
      end
    end else begin : g_no_flop_mem
      assign dout_q = mem_dout;
    end
  endgenerate

  // The read tag travels alongside the bank access.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      tag_vld <= '0;
    end else begin
      tag_vld[0] <= read;
      for (int i = 1; i < TAG_DEPTH; i++) begin
        tag_vld[i] <= tag_vld[i-1];
      end
    end
  end

  always_ff @(posedge clk) begin
    tag_bank[0] <= rd_bank;
    tag_row[0]  <= rd_row;
    for (int i = 1; i < TAG_DEPTH; i++) begin
      tag_bank[i] <= tag_bank[i-1];
      tag_row[i]  <= tag_row[i-1];
    end
  end

  assign res_vld  = tag_vld[TAG_DEPTH-1];
  assign res_dout = dout_q[tag_bank[TAG_DEPTH-1]];
  assign res_padr = {tag_bank[TAG_DEPTH-1], tag_row[TAG_DEPTH-1]};

  generate
    if (FLOPOUT != 0) begin : g_flop_out
      always_ff @(posedge clk) begin
        if (!rst_n) begin
          rd_vld <= 1'b0;
        end else begin
          rd_vld <= res_vld;
        end
      end

      always_ff @(posedge clk) begin
        rd_dout <= res_dout;
        rd_padr <= res_padr;
      end
    end else begin : g_no_flop_out
      assign rd_vld  = res_vld;
      assign rd_dout = res_dout;
      assign rd_padr = res_padr;
    end
  endgenerate

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Builds the pseudo two-port memory testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert --top-module pseudo_mem_tb \
  -f src.f -Mdir "$OBJ" -o pseudo_mem_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$OBJ/pseudo_mem_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "SIMULATION FAILED" "$LOG"; then
  exit 1
fi
if ! grep -q "SIMULATION PASSED" "$LOG"; then
  echo "no result line found in $LOG"
  exit 1
fi
exit 0

/* sim/pseudo_mem_assert.sv */
`default_nettype none

module pseudo_mem_assert
  import mem_pkg::*;
#(
  parameter int SRAM_DELAY = 2,
  parameter int FLOPCMD    = 1,
  parameter int FLOPMEM    = 0,
  parameter int FLOPOUT    = 1
) (
  input wire                clk,
  input wire                rst_n,
  input wire                read,
  input wire                write,
  input bank_t              rd_bank,
  input bank_t              wr_bank,
  input logic [NUMWBNK-1:0] mem_read,
  input logic [NUMWBNK-1:0] mem_write,
  input wire                rd_vld
);

  localparam int LAT = SRAM_DELAY + FLOPCMD + FLOPMEM + FLOPOUT;

  int fail_count = 0;

  no_bank_conflict: assert property (@(posedge clk) disable iff (!rst_n)
    !(read && write && (rd_bank == wr_bank)))
    else begin
      fail_count++;
      $error("read and write hit bank %0d in the same cycle", rd_bank);
    end

  read_latency: assert property (@(posedge clk) disable iff (!rst_n)
    rd_vld == $past(read, LAT))
    else begin
      fail_count++;
      $error("rd_vld does not follow read by %0d cycles", LAT);
    end

  one_strobe_per_bank: assert property (@(posedge clk) disable iff (!rst_n)
    (mem_read & mem_write) == '0)
    else begin
      fail_count++;
      $error("a bank got a read and a write strobe together");
    end

endmodule

bind stack_pseudo pseudo_mem_assert #(
  .SRAM_DELAY (SRAM_DELAY),
  .FLOPCMD    (FLOPCMD),
  .FLOPMEM    (FLOPMEM),
  .FLOPOUT    (FLOPOUT)
) i_pseudo_mem_assert (
  .clk       (clk),
  .rst_n     (rst_n),
  .read      (read),
  .write     (write),
  .rd_bank   (rd_bank),
  .wr_bank   (wr_bank),
  .mem_read  (mem_read),
  .mem_write (mem_write),
  .rd_vld    (rd_vld)
);

`default_nettype wire

/* sim/pseudo_mem_tb.sv */
`default_nettype none

module pseudo_mem_tb
  import mem_pkg::*;
();

  localparam int SRAM_DELAY = 2;
  localparam int FLOPCMD    = 1;
  localparam int FLOPMEM    = 0;
  localparam int FLOPOUT    = 1;
  localparam int LAT        = SRAM_DELAY + FLOPCMD + FLOPMEM + FLOPOUT;

  // Idle, fill, read-back, partial, read-after-write, back-to-back, random.
  localparam int OPS_PLANNED    = 10 + NUMADDR + 12 + 32 + 16 + 32 + 200;
  localparam int TIMEOUT_CYCLES = (OPS_PLANNED + 50) * 2;

  logic  clk;
  logic  rst_n;
  logic  write;
  addr_t wr_adr;
  word_t bw;
  word_t din;
  logic  read;
  addr_t rd_adr;
  logic  rd_vld;
  word_t rd_dout;
  padr_t rd_padr;

  word_t  shadow [NUMADDR];
  word_t  exp_data [$];
  padr_t  exp_padr [$];
  int     exp_cycle [$];
  int     cycle_count = 0;
  int     errors = 0;
  int     checks = 0;
  int     assert_fails;
  integer seed = 32'h6e5e1def;

  tb_clock #(.PERIOD(20)) i_tb_clock (.clk(clk));

  pseudo_mem_top #(
    .SRAM_DELAY (SRAM_DELAY),
    .FLOPCMD    (FLOPCMD),
    .FLOPMEM    (FLOPMEM),
    .FLOPOUT    (FLOPOUT)
  ) i_pseudo_mem_top (
    .clk     (clk),
    .rst_n   (rst_n),
    .write   (write),
    .wr_adr  (wr_adr),
    .bw      (bw),
    .din     (din),
    .read    (read),
    .rd_adr  (rd_adr),
    .rd_vld  (rd_vld),
    .rd_dout (rd_dout),
    .rd_padr (rd_padr)
  );

  function automatic int bank_of(input addr_t a);
    return int'(a) % NUMWBNK;
  endfunction

  function automatic padr_t expected_padr(input addr_t a);
    int bank_idx;
    int row_idx;
    bank_idx = int'(a) % NUMWBNK;
    row_idx  = int'(a) / NUMWBNK;
    return {bank_t'(bank_idx), row_t'(row_idx)};
  endfunction

  // Each bit whose mask bit is set takes the new value.
  function automatic word_t merge_masked(input word_t old, input word_t m, input word_t d);
    word_t res;
    res = old;
    for (int b = 0; b < WIDTH; b++) begin
      if (m[b]) begin
        res[b] = d[b];
      end
    end
    return res;
  endfunction

  function automatic word_t fill_pattern(input addr_t a);
    return {a, ~a, a, 2'b01};  // Every address bit shows up in the word.
  endfunction

  function automatic addr_t random_addr();
    integer r;
    r = $random(seed);
    return addr_t'($unsigned(r) % NUMADDR);
  endfunction

  task automatic compare_word(input string name, input word_t got, input word_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error at %0t: %s got %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic compare_padr(input string name, input padr_t got, input padr_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error at %0t: %s got %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic compare_count(input string name, input int got, input int exp);
    checks++;
    if (got != exp) begin
      errors++;
      $display("error at %0t: %s got %0d, expected %0d", $time, name, got, exp);
    end
  endtask

  // One bus cycle; a read sees the memory as it was before this cycle's write.
  task automatic do_cycle(input logic do_wr, input addr_t wa, input word_t m, input word_t d,
                          input logic do_rd, input addr_t ra);
    @(posedge clk);
    #2;
    write  = do_wr;
    wr_adr = wa;
    bw     = m;
    din    = d;
    read   = do_rd;
    rd_adr = ra;
    if (do_rd) begin
      exp_data.push_back(shadow[ra]);
      exp_padr.push_back(expected_padr(ra));
      exp_cycle.push_back(cycle_count);
    end
    if (do_wr) begin
      shadow[wa] = merge_masked(shadow[wa], m, d);
    end
  endtask

  task automatic idle_cycle();
    do_cycle(1'b0, '0, '0, '0, 1'b0, '0);
  endtask

  task automatic end_test(input string name, input int errors_before);
    idle_cycle();
    while (exp_data.size() != 0) begin
      @(posedge clk);
    end
    $display("%s finished with %0d errors", name, errors - errors_before);
  endtask

  task automatic test_reset_idle();
    int start;
    start = errors;
    repeat (10) idle_cycle();  // Any rd_vld here has no read behind it.
    end_test("test_reset_idle", start);
  endtask

  task automatic test_full_writes();
    int    start;
    addr_t rd_list [12];
    start   = errors;
    rd_list = '{0, 1, 2, 3, 5, 258, 513, 700, NUMADDR - 4, NUMADDR - 3, NUMADDR - 2,
                NUMADDR - 1};
    for (int a = 0; a < NUMADDR; a++) begin
      do_cycle(1'b1, addr_t'(a), '1, fill_pattern(addr_t'(a)), 1'b0, '0);
    end
    foreach (rd_list[i]) begin
      do_cycle(1'b0, '0, '0, '0, 1'b1, rd_list[i]);
    end
    end_test("test_full_writes", start);
  endtask

  task automatic test_partial_masks();
    int    start;
    addr_t a;
    word_t m;
    start = errors;
    for (int i = 0; i < 16; i++) begin
      a = random_addr();
      m = (i == 0) ? '0 : word_t'($random(seed));
      do_cycle(1'b1, a, m, word_t'($random(seed)), 1'b0, '0);
      do_cycle(1'b0, '0, '0, '0, 1'b1, a);
    end
    end_test("test_partial_masks", start);
  endtask

  task automatic test_read_after_write();
    int    start;
    addr_t a;
    addr_t other;
    start = errors;
    for (int i = 0; i < 8; i++) begin
      a     = random_addr();
      other = addr_t'((int'(a) + 1) % NUMADDR);  // Neighbour lives in another bank.
      do_cycle(1'b1, a, '1, word_t'($random(seed)), 1'b0, '0);
      do_cycle(1'b1, other, '1, word_t'($random(seed)), 1'b1, a);
    end
    end_test("test_read_after_write", start);
  endtask

  task automatic test_back_to_back();
    int start;
    start = errors;
    for (int i = 0; i < 32; i++) begin
      // Write bank is always two banks away from the read bank.
      do_cycle(1'b1, addr_t'(602 + i), word_t'($random(seed)), word_t'($random(seed)),
               1'b1, addr_t'(100 + i));
    end
    end_test("test_back_to_back", start);
  endtask

  task automatic test_random_traffic();
    int     start;
    integer r;
    addr_t  ra;
    addr_t  wa;
    start = errors;
    for (int i = 0; i < 200; i++) begin
      r  = $random(seed);
      ra = random_addr();
      wa = random_addr();
      if (r[0] && r[1] && bank_of(ra) == bank_of(wa)) begin
        wa = addr_t'((int'(wa) + 1) % NUMADDR);
      end
      do_cycle(r[1], wa, word_t'($random(seed)), word_t'($random(seed)), r[0], ra);
    end
    end_test("test_random_traffic", start);
  endtask

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count > TIMEOUT_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  // Results are sampled mid-cycle, away from the edge that changes them.
  always @(negedge clk) begin
    if (rst_n) begin
      if (rd_vld) begin
        if (exp_data.size() == 0) begin
          errors++;
          $display("error at %0t: rd_vld got 1, expected 0", $time);
        end else begin
          compare_count("rd_vld latency", cycle_count - exp_cycle.pop_front(), LAT);
          compare_word("rd_dout", rd_dout, exp_data.pop_front());
          compare_padr("rd_padr", rd_padr, exp_padr.pop_front());
        end
      end else if (exp_cycle.size() != 0 && cycle_count - exp_cycle[0] > LAT) begin
        errors++;
        $display("read result for rd_padr %h never arrived", exp_padr[0]);
        void'(exp_cycle.pop_front());
        void'(exp_data.pop_front());
        void'(exp_padr.pop_front());
      end
    end
  end

  initial begin
    rst_n  = 1'b0;
    write  = 1'b0;
    wr_adr = '0;
    bw     = '0;
    din    = '0;
    read   = 1'b0;
    rd_adr = '0;
    repeat (5) @(posedge clk);
    #2;
    rst_n = 1'b1;
    test_reset_idle();
    test_full_writes();
    test_partial_masks();
    test_read_after_write();
    test_back_to_back();
    test_random_traffic();
    assert_fails = i_pseudo_mem_top.i_stack_pseudo.i_pseudo_mem_assert.fail_count;
    if (assert_fails != 0) begin
      errors = errors + assert_fails;
      $display("%0d assertion failures were flagged on the controller", assert_fails);
    end
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sim/tb_clock.sv */
`default_nettype none

module tb_clock #(
  parameter int PERIOD = 20
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

endmodule

`default_nettype wire

/* src.f */
design/mem_pkg.sv
design/mem_bank_if.sv
design/np2_addr.sv
design/sram_bank.sv
design/stack_pseudo.sv
design/pseudo_mem_top.sv
sim/tb_clock.sv
sim/pseudo_mem_assert.sv
sim/pseudo_mem_tb.sv
